// ==== Makefile ====
# Verilator flow for the FDC command/status path

LOG = sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f fdc_top.f --top-module tb_fdc \
		--Mdir obj_dir -o sim_fdc

run: build
	./obj_dir/sim_fdc | tee $(LOG)
	@if grep -q "Simulation failed" $(LOG); then echo "run FAILED"; exit 1; fi
	@grep -q "Simulation passed" $(LOG) || (echo "run ended without a result"; exit 1)

lint:
	verilator --lint-only --timing --assert -f fdc_top.f --top-module fdc_top

clean:
	rm -rf obj_dir $(LOG)

// ==== common/fdc_cmd_pkg.sv ====
// ======================================
// command side types: bus bytes, cylinders, opcodes
// and the decoded command handed from decode to execute
// ======================================
`include "fdc_macros.svh"

package fdc_cmd_pkg;

	// one byte on the host bus
	typedef logic [`FDC_DATA_W-1:0] fdc_byte_t;

	// cylinder number, same width as a bus byte
	typedef logic [`FDC_DATA_W-1:0] fdc_cyl_t;

	// supported commands, everything else lands on OP_INVALID
	typedef enum logic [2:0] {
		OP_SEEK,
		OP_RECAL,
		OP_SPECIFY,
		OP_SENSE_INT,
		OP_SENSE_DRIVE,
		OP_INVALID
	} fdc_op_t;

	// ======================================
	// decoded command, 12 bits
	// ======================================
	typedef struct packed {
		fdc_op_t  op;    // classified opcode
		logic     drive; // bit 0 of first parameter
		fdc_cyl_t ncn;   // new cylinder, SEEK only
	} fdc_cmd_t;

endpackage

// ==== common/fdc_macros.svh ====
// ======================================
// shared widths, status codes and bit positions for the FDC
// include wherever these constants are needed
// ======================================
`ifndef FDC_MACROS_SVH
`define FDC_MACROS_SVH

// host data bus
`define FDC_DATA_W 8

// ST0 values returned by SENSE INTERRUPT STATUS / invalid commands
`define FDC_ST0_SEEK_END 8'h20
`define FDC_ST0_SEEK_ERR 8'hE8
`define FDC_ST0_INVALID  8'h80

// main status register bits
`define FDC_MSR_CB  4
`define FDC_MSR_DIO 6
`define FDC_MSR_RQM 7

// ST3 bits
`define FDC_ST3_T0 4
`define FDC_ST3_WP 6

// max bytes in one result phase
`define FDC_MAX_RESULTS 2

`endif

// ==== common/fdc_status_pkg.sv ====
// ======================================
// status side types: the result record from execute
// and the main status register seen by the host
// ======================================
`include "fdc_macros.svh"

package fdc_status_pkg;

	import fdc_cmd_pkg::*;

	// ======================================
	// result record, 18 bits
	// ======================================
	// count of zero means the command has no result phase.
	// bytes[0] is the first byte the host reads
	typedef struct packed {
		logic [1:0] count;
		fdc_byte_t [0:`FDC_MAX_RESULTS-1] bytes;
	} fdc_result_t;

	// main status register, RQM / DIO / CB used here
	typedef logic [7:0] fdc_msr_t;

endpackage

// ==== decode/fdc_cmd_decode.sv ====
// ======================================
// host strobe edge detect and command byte collection
// emits one decoded command per complete byte sequence
// ======================================
`timescale 1ns/1ps

module fdc_cmd_decode
	import fdc_cmd_pkg::*;
(
	input  logic      clk_sys,
	input  logic      reset,
	input  logic      a0,
	input  logic      rd_n,
	input  logic      wr_n,
	input  fdc_byte_t din,
	input  logic      result_busy, // host must drain results first
	output logic      rd_pulse,
	output fdc_cmd_t  cmd,
	output logic      cmd_valid,
	output logic      collecting
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_COLLECT,
		ST_DONE
	} dec_state_t;

	dec_state_t state;
	logic       wr_last;
	logic       rd_last;
	logic       wr_pulse;
	logic [1:0] left;     // parameter bytes still to come
	logic       first;    // next byte is the drive select byte
	logic       wr_byte;
	fdc_op_t    op_in;
	logic [1:0] n_params;

	// ======================================
	// strobe edges
	// ======================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			wr_last  <= 1'b1;
			rd_last  <= 1'b1;
			wr_pulse <= 1'b0;
			rd_pulse <= 1'b0;
		end else begin
			wr_last  <= wr_n;
			rd_last  <= rd_n;
			wr_pulse <= wr_last & ~wr_n; // high then low
			rd_pulse <= rd_last & ~rd_n;
		end
	end

	// data register writes only, dropped during a result phase
	assign wr_byte = wr_pulse & a0 & ~result_busy;

	// opcode classification, upper three bits must be zero
	always_comb begin
		op_in    = OP_INVALID;
		n_params = 2'd0;
		if (din[7:5] == 3'b000) begin
			case (din[4:0])
				5'h0F: begin
					op_in    = OP_SEEK;
					n_params = 2'd2;
				end
				5'h07: begin
					op_in    = OP_RECAL;
					n_params = 2'd1;
				end
				5'h03: begin
					op_in    = OP_SPECIFY;
					n_params = 2'd2;
				end
				5'h08: op_in = OP_SENSE_INT;
				5'h04: begin
					op_in    = OP_SENSE_DRIVE;
					n_params = 2'd1;
				end
				default: op_in = OP_INVALID;
			endcase
		end
	end

	// ======================================
	// command FSM
	// ======================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state <= ST_IDLE;
			left  <= 2'd0;
			first <= 1'b0;
		end else begin
			case (state)
				ST_IDLE: if (wr_byte) begin
					left  <= n_params;
					first <= 1'b1;
					state <= (n_params == 2'd0) ? ST_DONE : ST_COLLECT;
				end
				ST_COLLECT: if (wr_byte) begin
					first <= 1'b0;
					left  <= left - 2'd1;
					if (left == 2'd1)
						state <= ST_DONE;
				end
				default: state <= ST_IDLE; // done lasts one cycle
			endcase
		end
	end

	// command payload
	always_ff @(posedge clk_sys) begin
		if (state == ST_IDLE && wr_byte) begin
			cmd.op    <= op_in;
			cmd.drive <= 1'b0;
			cmd.ncn   <= '0;
		end else if (state == ST_COLLECT && wr_byte) begin
			if (first)
				cmd.drive <= din[0];
			else
				cmd.ncn <= din; // second parameter
		end
	end

	assign cmd_valid  = (state == ST_DONE);
	assign collecting = (state == ST_COLLECT);

	// results must be fully read before the next command can complete
	a_no_cmd_in_result: assert property (@(posedge clk_sys) disable iff (reset)
		cmd_valid |-> !result_busy);

endmodule

// ==== fdc_top.f ====
+incdir+common
common/fdc_cmd_pkg.sv
common/fdc_status_pkg.sv
decode/fdc_cmd_decode.sv
logic/fdc_drive_exec.sv
logic/fdc_result.sv
logic/fdc_top.sv
testbench/tb_clock.sv
testbench/tb_fdc.sv

// ==== logic/fdc_drive_exec.sv ====
// ======================================
// drive state and single cycle command execution
// builds the result record for the result stage
// ======================================
`timescale 1ns/1ps
`include "fdc_macros.svh"

module fdc_drive_exec
	import fdc_cmd_pkg::*;
	import fdc_status_pkg::*;
(
	input  logic        clk_sys,
	input  logic        reset,
	input  fdc_cmd_t    cmd,
	input  logic        cmd_valid,
	input  logic        img_mounted,
	input  fdc_cyl_t    img_tracks,
	output fdc_result_t res,
	output logic        res_valid,
	output logic        busy
);

	fdc_cyl_t    pcn;      // present cylinder
	fdc_byte_t   st0;
	logic        int_pend; // seek/recal finished, not yet sensed
	fdc_byte_t   st3;
	logic        seek_ok;
	fdc_result_t res_d;

	assign seek_ok = (cmd.ncn == '0) || (img_mounted && (cmd.ncn < img_tracks));

	always_comb begin
		st3 = '0;
		st3[`FDC_ST3_WP] = ~img_mounted;
		st3[`FDC_ST3_T0] = (pcn == '0);
	end

	// ======================================
	// result record per command
	// ======================================
	always_comb begin
		res_d = '0;
		case (cmd.op)
			OP_SENSE_INT: if (int_pend) begin
				res_d.count    = 2'd2;
				res_d.bytes[0] = st0;
				res_d.bytes[1] = pcn;
			end else begin
				res_d.count    = 2'd1; // nothing pending, treated as invalid
				res_d.bytes[0] = `FDC_ST0_INVALID;
			end
			OP_SENSE_DRIVE: begin
				res_d.count    = 2'd1;
				res_d.bytes[0] = cmd.drive ? 8'h01 : st3;
			end
			OP_INVALID: begin
				res_d.count    = 2'd1;
				res_d.bytes[0] = `FDC_ST0_INVALID;
			end
			default: res_d.count = 2'd0; // seek, recal, specify
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			pcn       <= '0;
			st0       <= '0;
			int_pend  <= 1'b0;
			res_valid <= 1'b0;
		end else begin
			res_valid <= cmd_valid;
			if (cmd_valid) begin
				case (cmd.op)
					OP_SEEK: begin
						int_pend <= 1'b1;
						if (seek_ok) begin
							pcn <= cmd.ncn;
							st0 <= `FDC_ST0_SEEK_END;
						end else begin
							st0 <= `FDC_ST0_SEEK_ERR; // cylinder stays
						end
					end
					OP_RECAL: begin
						pcn      <= '0;
						st0      <= `FDC_ST0_SEEK_END;
						int_pend <= 1'b1;
					end
					OP_SENSE_INT: int_pend <= 1'b0;
					default: ;
				endcase
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (cmd_valid)
			res <= res_d;
	end

	assign busy = cmd_valid; // the execute cycle

	// a completed seek never parks the head past the disk
	a_seek_in_range: assert property (@(posedge clk_sys) disable iff (reset)
		(cmd_valid && cmd.op == OP_SEEK && seek_ok)
		|=> ((pcn == '0) || (pcn < $past(img_tracks))));

endmodule

// ==== logic/fdc_result.sv ====
// ======================================
// result byte sequencing, main status register
// and the host read data register
// ======================================
`timescale 1ns/1ps
`include "fdc_macros.svh"

module fdc_result
	import fdc_cmd_pkg::*;
	import fdc_status_pkg::*;
(
	input  logic        clk_sys,
	input  logic        reset,
	input  logic        a0,
	input  logic        rd_pulse,
	input  logic        collecting,  // decode waits for parameters
	input  logic        busy,        // execute cycle
	input  fdc_result_t res,
	input  logic        res_valid,
	output logic        result_busy,
	output fdc_byte_t   dout
);

	fdc_result_t rec;       // held result record
	logic [1:0]  idx;       // next byte to hand out
	logic        res_phase;
	logic        last_byte;
	fdc_msr_t    msr;

	// result phase starts as soon as a record with bytes arrives
	assign res_phase = result_busy | (res_valid & (res.count != 2'd0));
	assign last_byte = ((idx + 2'd1) == rec.count);

	// ======================================
	// main status register
	// ======================================
	always_comb begin
		msr = '0;
		msr[`FDC_MSR_RQM] = ~busy;
		msr[`FDC_MSR_DIO] = res_phase;                      // data to host
		msr[`FDC_MSR_CB]  = busy | collecting | res_phase; // command in progress
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			result_busy <= 1'b0;
			idx         <= 2'd0;
			dout        <= 8'hFF;
		end else begin
			if (res_valid && res.count != 2'd0) begin
				result_busy <= 1'b1;
				idx         <= 2'd0;
			end

			if (rd_pulse) begin
				if (!a0) begin
					dout <= msr;
				end else if (result_busy) begin
					dout <= rec.bytes[idx[0]];
					idx  <= idx + 2'd1;
					if (last_byte)
						result_busy <= 1'b0; // back to idle
				end else begin
					dout <= 8'hFF; // no result pending
				end
			end
		end
	end

	// record payload
	always_ff @(posedge clk_sys) begin
		if (res_valid)
			rec <= res;
	end

	// sequencing stops at the last byte of the record
	a_idx_in_range: assert property (@(posedge clk_sys) disable iff (reset)
		result_busy |-> (idx < rec.count));

endmodule

// ==== logic/fdc_top.sv ====
// ======================================
// FDC command/status path top level
// host bus in, disk presence and track count in, read data out
// ======================================
`timescale 1ns/1ps

module fdc_top
	import fdc_cmd_pkg::*;
	import fdc_status_pkg::*;
(
	input  logic      clk_sys,
	input  logic      reset,
	input  logic      a0,
	input  logic      rd_n,        // active low read strobe
	input  logic      wr_n,        // active low write strobe
	input  fdc_byte_t din,
	output fdc_byte_t dout,
	input  logic      img_mounted, // disk present
	input  fdc_cyl_t  img_tracks   // cylinders on the disk
);

	logic        rd_pulse;
	fdc_cmd_t    cmd;
	logic        cmd_valid;
	logic        collecting;
	fdc_result_t res;
	logic        res_valid;
	logic        busy;
	logic        result_busy;

	// strobe edges, opcode and parameters
	fdc_cmd_decode i_decode (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.a0          (a0),
		.rd_n        (rd_n),
		.wr_n        (wr_n),
		.din         (din),
		.result_busy (result_busy),
		.rd_pulse    (rd_pulse),
		.cmd         (cmd),
		.cmd_valid   (cmd_valid),
		.collecting  (collecting)
	);

	// drive state and one cycle execution
	fdc_drive_exec i_exec (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.cmd         (cmd),
		.cmd_valid   (cmd_valid),
		.img_mounted (img_mounted),
		.img_tracks  (img_tracks),
		.res         (res),
		.res_valid   (res_valid),
		.busy        (busy)
	);

	// result phase, MSR and read data
	fdc_result i_result (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.a0          (a0),
		.rd_pulse    (rd_pulse),
		.collecting  (collecting),
		.busy        (busy),
		.res         (res),
		.res_valid   (res_valid),
		.result_busy (result_busy),
		.dout        (dout)
	);

endmodule

// ==== testbench/tb_clock.sv ====
// ========================================
// testbench clock and reset source
// 20 ns clk_sys, reset high for the first two cycles
// ========================================
`timescale 1ns/1ps

module tb_clock (
	output logic clk_sys,
	output logic reset
);

	initial begin
		clk_sys = 1'b0;
		forever #10 clk_sys = ~clk_sys;
	end

	initial begin
		reset = 1'b1;
		repeat (2) @(posedge clk_sys);
		@(negedge clk_sys); // release away from the sampling edge
		reset = 1'b0;
	end

endmodule

// ==== testbench/tb_fdc.sv ====
// ========================================
// testbench for the FDC command/status path
// drives the host bus like a CPU polling the main status register
// ========================================
`timescale 1ns/1ps

module tb_fdc
	import fdc_cmd_pkg::*;
;

	localparam logic [7:0] MSR_IDLE   = 8'h80;
	localparam logic [7:0] MSR_PARAM  = 8'h90;
	localparam logic [7:0] MSR_RESULT = 8'hD0;
	localparam logic [7:0] ST0_OK     = 8'h20;
	localparam logic [7:0] ST0_ERR    = 8'hE8;
	localparam logic [7:0] ST0_BAD    = 8'h80;
	localparam int         MSR_TRIES  = 50;

	logic      clk_sys;
	logic      reset;
	logic      a0;
	logic      rd_n;
	logic      wr_n;
	fdc_byte_t din;
	fdc_byte_t dout;
	logic      img_mounted;
	fdc_cyl_t  img_tracks;
	logic [7:0] lfsr_state;
	logic [7:0] rnd;
	fdc_cyl_t  good_cyl;
	fdc_cyl_t  other_cyl;
	int        wait_cnt;

	tb_clock i_clock (.clk_sys(clk_sys), .reset(reset));

	fdc_top i_dut (
		.clk_sys(clk_sys), .reset(reset), .a0(a0), .rd_n(rd_n), .wr_n(wr_n),
		.din(din), .dout(dout), .img_mounted(img_mounted), .img_tracks(img_tracks)
	);

	task automatic abort_run();
		$display("Simulation failed");
		$fatal(1, "aborting after first error");
	endtask

	// ========================================
	// bus checks
	// ========================================
	// read data only moves two clocks after a read strobe went low
	a_dout_holds: assert property (@(posedge clk_sys) disable iff (reset)
		$changed(dout) |-> !$past(rd_n, 2))
	else begin
		$display("[FAIL] %0t: dout changed without a read access", $time);
		abort_run();
	end

	// galois form, x^8+x^6+x^5+x^4+1
	function automatic logic [7:0] lfsr_next(input logic [7:0] s);
		lfsr_next = s[0] ? ((s >> 1) ^ 8'hB8) : (s >> 1);
	endfunction

	task automatic random_bits(input int n, output logic [7:0] val);
		val = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			val = {val[6:0], lfsr_state[0]}; // one step per bit
		end
	endtask

	// ST3 for drive 0, straight from the status bit definitions
	function automatic logic [7:0] expected_st3(input logic mounted, input fdc_cyl_t cyl);
		expected_st3 = {1'b0, ~mounted, 1'b0, (cyl == 8'd0), 4'h0};
	endfunction

	task automatic bus_write(input logic addr, input fdc_byte_t data);
		@(negedge clk_sys);
		a0   = addr;
		din  = data;
		wr_n = 1'b0;
		repeat (3) @(negedge clk_sys);
		wr_n = 1'b1;
		repeat (3) @(negedge clk_sys);
	endtask

	task automatic bus_read(input logic addr, output fdc_byte_t data);
		@(negedge clk_sys);
		a0   = addr;
		rd_n = 1'b0;
		repeat (3) @(negedge clk_sys);
		data = dout; // loaded two clocks ago, stable now
		rd_n = 1'b1;
		repeat (3) @(negedge clk_sys);
	endtask

	task automatic check_read(input logic addr, input fdc_byte_t exp, input string what);
		fdc_byte_t got;
		bus_read(addr, got);
		assert (got === exp)
		else begin
			$display("[FAIL] %0t: %s read %02h, expected %02h", $time, what, got, exp);
			abort_run();
		end
	endtask

	task automatic wait_msr(input fdc_byte_t exp, input string what);
		fdc_byte_t got;
		int tries;
		tries = 0;
		bus_read(1'b0, got);
		while (got !== exp && tries < MSR_TRIES) begin
			tries++;
			bus_read(1'b0, got);
		end
		if (got !== exp) begin
			$display("timed out waiting for status %02h (%s), last read %02h", exp, what, got);
			abort_run();
		end
	endtask

	task automatic sense_int(input fdc_byte_t st0, input fdc_cyl_t cyl);
		bus_write(1'b1, 8'h08);
		wait_msr(MSR_RESULT, "sense interrupt result");
		check_read(1'b1, st0, "sense interrupt ST0");
		check_read(1'b1, cyl, "sense interrupt cylinder");
		wait_msr(MSR_IDLE, "after sense interrupt");
	endtask

	task automatic seek_to(input fdc_cyl_t cyl);
		bus_write(1'b1, 8'h0F);
		check_read(1'b0, MSR_PARAM, "status before drive byte");
		bus_write(1'b1, 8'h00);
		check_read(1'b0, MSR_PARAM, "status before cylinder byte");
		bus_write(1'b1, cyl);
		wait_msr(MSR_IDLE, "after seek");
	endtask

	task automatic sense_drive(input logic drive, input fdc_byte_t exp);
		bus_write(1'b1, 8'h04);
		bus_write(1'b1, {7'd0, drive});
		wait_msr(MSR_RESULT, "sense drive result");
		check_read(1'b1, exp, "sense drive ST3");
		wait_msr(MSR_IDLE, "after sense drive");
	endtask

	task automatic single_byte_result(input fdc_byte_t opcode, input string what);
		bus_write(1'b1, opcode);
		wait_msr(MSR_RESULT, what);
		check_read(1'b1, ST0_BAD, what);
		wait_msr(MSR_IDLE, what);
	endtask

	task automatic set_disk(input logic mounted, input fdc_cyl_t tracks);
		@(negedge clk_sys);
		img_mounted = mounted;
		img_tracks  = tracks;
	endtask

	// ========================================
	// stimulus
	// ========================================
	initial begin
		a0          = 1'b0;
		rd_n        = 1'b1;
		wr_n        = 1'b1;
		din         = '0;
		img_mounted = 1'b0;
		img_tracks  = '0;
		lfsr_state  = 8'd2;
		wait_cnt    = 0;
		while (reset !== 1'b0 && wait_cnt < 20) begin
			wait_cnt++;
			@(negedge clk_sys);
		end
		if (reset !== 1'b0) begin
			$display("reset was never released");
			abort_run();
		end

		// idle, then sense interrupt with nothing pending
		wait_msr(MSR_IDLE, "after reset");
		single_byte_result(8'h08, "sense interrupt, nothing pending");

		// seek inside the disk
		set_disk(1'b1, 8'd40);
		random_bits(6, rnd);
		good_cyl = rnd % 8'd40;
		if (good_cyl == 8'd0)
			good_cyl = 8'd1; // keep it apart from track 0
		seek_to(good_cyl);
		sense_int(ST0_OK, good_cyl);

		// past the last track, then with no disk
		random_bits(6, rnd);
		seek_to(8'd40 + rnd);
		sense_int(ST0_ERR, good_cyl);
		set_disk(1'b0, 8'd40);
		random_bits(5, rnd);
		other_cyl = rnd + 8'd1;
		seek_to(other_cyl);
		sense_int(ST0_ERR, good_cyl);

		// recalibrate and drive status, disk out then in
		bus_write(1'b1, 8'h07);
		bus_write(1'b1, 8'h00);
		wait_msr(MSR_IDLE, "after recalibrate");
		sense_int(ST0_OK, 8'd0);
		single_byte_result(8'h08, "interrupt already sensed");
		sense_drive(1'b0, expected_st3(img_mounted, 8'd0));
		set_disk(1'b1, 8'd40);
		sense_drive(1'b0, expected_st3(img_mounted, 8'd0));
		sense_drive(1'b1, 8'h01);

		// specify, invalid opcode, stray data read
		bus_write(1'b1, 8'h03);
		bus_write(1'b1, 8'hAF);
		bus_write(1'b1, 8'h02);
		check_read(1'b0, MSR_IDLE, "status after specify");
		check_read(1'b1, 8'hFF, "data read outside result phase");
		single_byte_result(8'h06, "invalid opcode");

		$display("Simulation passed");
		$finish;
	end

endmodule
